// File: common/mvu_data_pkg.sv
// --------------------------------------------------
// Word widths and element types of the MVU datapath
// Activations and weights are signed two's complement
// dst_width must hold SF*SIMD products without overflow
// Products and adder sums use the accumulator type
// --------------------------------------------------

package mvu_data_pkg;

   // Activation word width in bits
   localparam int src_width = 4;

   // Weight word width in bits
   localparam int wgt_width = 4;

   // An accumulator width of 16 bits leaves ample headroom at the default sizes
   localparam int dst_width = 16;

   // One signed activation lane
   typedef logic signed [src_width-1:0] act_t;

   // One signed weight lane
   typedef logic signed [wgt_width-1:0] wgt_t;

   // Signed accumulator word, also carries the products and the adder sums
   typedef logic signed [dst_width-1:0] acc_t;

endpackage

// File: common/mvu_ctrl_pkg.sv
// --------------------------------------------------
// Control types shared by the FSM and the PE array
// Strobes are valid only in the cycle of their beat
// --------------------------------------------------

package mvu_ctrl_pkg;

   // Run states of the control FSM
   typedef enum logic [1:0] {
      idle  = 2'd0,
      run   = 2'd1,
      drain = 2'd2
   } mvu_state_e;

   // Strobes broadcast to every processing element
   typedef struct packed {
      // Input lanes are accepted this cycle
      logic beat;
      // This beat is the first synapse fold of an output
      logic sf_clr;
      // This beat is the last synapse fold of an output
      logic sf_last;
   } pe_ctrl_t;

endpackage

// File: pe/mvu_pe_simd.sv
// --------------------------------------------------
// SIMD multiplier stage of one processing element
// One register stage with sign extended products
// Empty beats register zero products
// --------------------------------------------------

`timescale 1ns/1ps

module mvu_pe_simd
   import mvu_data_pkg::*;
#(
   parameter int SIMD = 4
) (
   input  logic clk,
   input  logic rst_n,
   input  logic beat,
   input  act_t act [SIMD],
   input  wgt_t wgt [SIMD],
   output acc_t prod [SIMD]
);

   // Each lane is an independent signed multiplier
   for (genvar i = 0; i < SIMD; i++) begin : g_lane

      always_ff @(posedge clk) begin
         if (!rst_n) begin
            // Clean products after reset keep the accumulators at zero
            prod[i] <= '0;
         end else if (beat) begin
            // Both operands are widened first so the product keeps its sign
            prod[i] <= acc_t'(act[i]) * acc_t'(wgt[i]);
         end else begin
            // A gap contributes nothing to the running sum
            prod[i] <= '0;
         end
      end

   end

endmodule

// File: pe/mvu_pe_adder.sv
// --------------------------------------------------
// Adder stage of one processing element
// Sums all SIMD products into one registered word
// Overflow wraps silently at dst_width bits
// --------------------------------------------------

`timescale 1ns/1ps

module mvu_pe_adder
   import mvu_data_pkg::*;
#(
   parameter int SIMD = 4
) (
   input  logic clk,
   input  logic rst_n,
   input  acc_t prod [SIMD],
   output acc_t sum
);

   // Combinational sum of all lanes ahead of the register
   acc_t lane_sum;

   always_comb begin
      lane_sum = '0;
      // Lanes are added in order into one signed word
      for (int i = 0; i < SIMD; i++) begin
         lane_sum = lane_sum + prod[i];
      end
   end

   // One register stage between the multipliers and the accumulator
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sum <= '0;
      end else begin
         sum <= lane_sum;
      end
   end

endmodule

// File: pe/mvu_pe_acc.sv
// --------------------------------------------------
// Accumulator over the synapse folds of one output
// sf_clr arrives with the beat and is delayed 2 cycles
// The first fold loads, later folds add
// --------------------------------------------------

`timescale 1ns/1ps

module mvu_pe_acc
   import mvu_data_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   input  logic sf_clr,
   input  acc_t in_acc,
   output acc_t out_acc
);

   // Clear strobe travelling alongside the multiplier and adder registers
   logic [1:0] sf_clr_dly;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sf_clr_dly <= '0;
      end else begin
         sf_clr_dly <= {sf_clr_dly[0], sf_clr};
      end
   end

   // The delayed clear lines up with the sum of the first fold
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_acc <= '0;
      end else if (sf_clr_dly[1]) begin
         // Start a new dot product, dropping the previous one
         out_acc <= in_acc;
      end else begin
         out_acc <= out_acc + in_acc;
      end
   end

endmodule

// File: pe/mvu_pe.sv
// --------------------------------------------------
// One processing element computing one row per fold
// Latency from beat to out_acc is three cycles
// Activations are shared, weights are per element
// --------------------------------------------------

`timescale 1ns/1ps

module mvu_pe
   import mvu_data_pkg::*;
   import mvu_ctrl_pkg::*;
#(
   parameter int SIMD = 4
) (
   input  logic     clk,
   input  logic     rst_n,
   input  pe_ctrl_t ctrl,
   input  act_t     act [SIMD],
   input  wgt_t     wgt [SIMD],
   output acc_t     out_acc
);

   // Registered lane products
   acc_t prod [SIMD];
   // Registered sum of the lanes
   acc_t sum;

   // Multipliers see the beat strobe so gaps become zeros
   mvu_pe_simd #(
      .SIMD (SIMD)
   ) u_simd (
      .clk   (clk),
      .rst_n (rst_n),
      .beat  (ctrl.beat),
      .act   (act),
      .wgt   (wgt),
      .prod  (prod)
   );

   mvu_pe_adder #(
      .SIMD (SIMD)
   ) u_adder (
      .clk   (clk),
      .rst_n (rst_n),
      .prod  (prod),
      .sum   (sum)
   );

   // The accumulator delays sf_clr itself to match the two stages above
   mvu_pe_acc u_acc (
      .clk     (clk),
      .rst_n   (rst_n),
      .sf_clr  (ctrl.sf_clr),
      .in_acc  (sum),
      .out_acc (out_acc)
   );

endmodule

// File: design/mvu_fold_counter.sv
// --------------------------------------------------
// Synapse and neuron fold indices of accepted beats
// Counts on the edge that accepts the beat
// Both indices wrap, so a full matrix ends at zero
// --------------------------------------------------

`timescale 1ns/1ps

module mvu_fold_counter #(
   parameter int SF = 3,
   parameter int NF = 2
) (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic                               clear,
   input  logic                               count,
   output logic [$clog2(SF > 1 ? SF : 2)-1:0] sf_idx,
   output logic [$clog2(NF > 1 ? NF : 2)-1:0] nf_idx
);

   // Index widths keep at least one bit even for a single fold
   localparam int SF_W = $clog2(SF > 1 ? SF : 2);
   localparam int NF_W = $clog2(NF > 1 ? NF : 2);

   // Final values of each index
   logic sf_wrap;
   logic nf_wrap;

   assign sf_wrap = (sf_idx == SF_W'(SF - 1));
   assign nf_wrap = (nf_idx == NF_W'(NF - 1));

   always_ff @(posedge clk) begin
      if (!rst_n || clear) begin
         // A start always begins at the first fold of the matrix
         sf_idx <= '0;
         nf_idx <= '0;
      end else if (count) begin
         if (sf_wrap) begin
            sf_idx <= '0;
            // The neuron fold only moves when a full row of folds is done
            if (nf_wrap) begin
               nf_idx <= '0;
            end else begin
               nf_idx <= nf_idx + NF_W'(1);
            end
         end else begin
            sf_idx <= sf_idx + SF_W'(1);
         end
      end
   end

endmodule

// File: design/mvu_ctrl_fsm.sv
// --------------------------------------------------
// Run control of the MVU
// Beats count only in run with in_valid high
// out_valid and done trail sf_last by three cycles
// Start is ignored while busy
// --------------------------------------------------

`timescale 1ns/1ps

module mvu_ctrl_fsm
   import mvu_ctrl_pkg::*;
#(
   parameter int SF = 3,
   parameter int NF = 2
) (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic                               start,
   input  logic                               in_valid,
   input  logic [$clog2(SF > 1 ? SF : 2)-1:0] sf_idx,
   input  logic [$clog2(NF > 1 ? NF : 2)-1:0] nf_idx,
   output pe_ctrl_t                           ctrl,
   output logic                               count,
   output logic                               clear,
   output logic                               busy,
   output logic                               out_valid,
   output logic                               done
);

   localparam int SF_W = $clog2(SF > 1 ? SF : 2);
   localparam int NF_W = $clog2(NF > 1 ? NF : 2);

   mvu_state_e state;
   mvu_state_e state_nxt;

   // Position of the current beat within the matrix
   logic last_sf;
   logic last_nf;
   logic last_beat;

   // Shift registers matching the multiplier, adder and accumulator stages
   logic [2:0] vld_sr;
   logic [2:0] end_sr;

   assign last_sf = (sf_idx == SF_W'(SF - 1));
   assign last_nf = (nf_idx == NF_W'(NF - 1));

   // Strobes are formed in the same cycle as the beat they describe
   assign ctrl.beat    = (state == run) && in_valid;
   assign ctrl.sf_clr  = ctrl.beat && (sf_idx == '0);
   assign ctrl.sf_last = ctrl.beat && last_sf;
   assign last_beat    = ctrl.sf_last && last_nf;

   assign count = ctrl.beat;
   // Counter restarts together with the move to run
   assign clear = (state == idle) && start;
   assign busy  = (state != idle);

   always_comb begin
      state_nxt = state;
      case (state)
         idle: begin
            if (start) begin
               state_nxt = run;
            end
         end
         run: begin
            if (last_beat) begin
               state_nxt = drain;
            end
         end
         drain: begin
            // Leave on the edge that raises out_valid and done
            if (end_sr[1]) begin
               state_nxt = idle;
            end
         end
         default: state_nxt = idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state  <= idle;
         vld_sr <= '0;
         end_sr <= '0;
      end else begin
         state  <= state_nxt;
         vld_sr <= {vld_sr[1:0], ctrl.sf_last};
         end_sr <= {end_sr[1:0], last_beat};
      end
   end

   // The last stage coincides with the final accumulator value
   assign out_valid = vld_sr[2];
   assign done      = end_sr[2];

endmodule

// File: design/mvu_top.sv
// --------------------------------------------------
// Matrix-vector unit taking PE rows by SIMD lanes per beat
// Matrix is NF*PE rows by SF*SIMD columns
// out_acc must be taken on out_valid as nothing stalls
// Weights are streamed in and nothing is stored on chip
// --------------------------------------------------

`timescale 1ns/1ps

module mvu_top
   import mvu_data_pkg::*;
   import mvu_ctrl_pkg::*;
#(
   parameter int SIMD = 4,
   parameter int PE   = 2,
   parameter int SF   = 3,
   parameter int NF   = 2
) (
   input  logic clk,
   input  logic rst_n,
   input  logic start,
   input  logic in_valid,
   input  act_t in_act [SIMD],
   input  wgt_t in_wgt [PE][SIMD],
   output logic busy,
   output logic out_valid,
   output acc_t out_acc [PE],
   output logic done
);

   localparam int SF_W = $clog2(SF > 1 ? SF : 2);
   localparam int NF_W = $clog2(NF > 1 ? NF : 2);

   // Strobes shared by every processing element
   pe_ctrl_t        ctrl;
   logic            count;
   logic            clear;
   logic [SF_W-1:0] sf_idx;
   logic [NF_W-1:0] nf_idx;

   mvu_ctrl_fsm #(
      .SF (SF),
      .NF (NF)
   ) u_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (start),
      .in_valid  (in_valid),
      .sf_idx    (sf_idx),
      .nf_idx    (nf_idx),
      .ctrl      (ctrl),
      .count     (count),
      .clear     (clear),
      .busy      (busy),
      .out_valid (out_valid),
      .done      (done)
   );

   mvu_fold_counter #(
      .SF (SF),
      .NF (NF)
   ) u_cnt (
      .clk    (clk),
      .rst_n  (rst_n),
      .clear  (clear),
      .count  (count),
      .sf_idx (sf_idx),
      .nf_idx (nf_idx)
   );

   // One element per matrix row of the current neuron fold
   for (genvar p = 0; p < PE; p++) begin : g_pe
      mvu_pe #(
         .SIMD (SIMD)
      ) u_pe (
         .clk     (clk),
         .rst_n   (rst_n),
         .ctrl    (ctrl),
         .act     (in_act),
         .wgt     (in_wgt[p]),
         .out_acc (out_acc[p])
      );
   end

endmodule

// File: bench/mvu_tb.sv
// --------------------------------------------------
// Testbench of the MVU top level with a software model
// Stimulus comes from an LCG with a fixed seed
// Inputs change 1 ns after the rising edge
// Outputs are checked on the falling edge
// A cycle counter bounds the whole run
// --------------------------------------------------

`timescale 1ns/1ps

module mvu_tb
   import mvu_data_pkg::*;
;

   localparam int SIMD = 4;
   localparam int PE   = 2;
   localparam int SF   = 3;
   localparam int NF   = 2;

   // Nine full runs plus one aborted run, and the idle noise cycles
   localparam int runs        = 10;
   localparam int idle_cycles = 8;
   localparam int total_beats = runs * NF * SF + idle_cycles;
   localparam int cycle_limit = 4 * total_beats + 200;

   // Extreme lane values follow from the package widths
   localparam act_t act_min = act_t'(-(1 << (src_width - 1)));
   localparam act_t act_max = act_t'((1 << (src_width - 1)) - 1);
   localparam wgt_t wgt_min = wgt_t'(-(1 << (wgt_width - 1)));
   localparam wgt_t wgt_max = wgt_t'((1 << (wgt_width - 1)) - 1);

   logic clk;
   logic rst_n;
   logic start;
   logic in_valid;
   act_t in_act [SIMD];
   wgt_t in_wgt [PE][SIMD];
   logic busy;
   logic out_valid;
   acc_t out_acc [PE];
   logic done;

   logic [31:0] seed;
   int          cycles;
   int          errors;
   int          tests_run;
   int          tests_failed;
   int          test_err0;
   int          ov_count;
   int          ov_before;
   string       test_name;

   // Expected words with PE entries per out_valid and a flag for the matrix end
   acc_t exp_acc_q [$];
   bit   exp_last_q [$];

   mvu_top #(
      .SIMD (SIMD),
      .PE   (PE),
      .SF   (SF),
      .NF   (NF)
   ) uut (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (start),
      .in_valid  (in_valid),
      .in_act    (in_act),
      .in_wgt    (in_wgt),
      .busy      (busy),
      .out_valid (out_valid),
      .out_acc   (out_acc),
      .done      (done)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Watchdog over the whole simulation
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > cycle_limit) begin
         $display("timeout after %0d cycles, the DUT never finished its matrix", cycles);
         $display("TESTS FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   task automatic check_acc(input string name, input acc_t got, input acc_t exp);
      if (got !== exp) begin
         $display("error %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("%s was %s when it should be %s", what,
                  got ? "high" : "low", exp ? "high" : "low");
         errors++;
      end
   endtask

   // Mode 0 is random data, 1 random extremes, 2 all lanes at the most negative value
   task automatic fill_inputs(input int mode);
      logic [31:0] r;
      for (int l = 0; l < SIMD; l++) begin
         r = next_rand();
         case (mode)
            1: in_act[l] = r[24] ? act_min : act_max;
            2: in_act[l] = act_min;
            default: in_act[l] = act_t'(r[16 +: src_width]);
         endcase
         for (int p = 0; p < PE; p++) begin
            r = next_rand();
            case (mode)
               1: in_wgt[p][l] = r[25] ? wgt_min : wgt_max;
               2: in_wgt[p][l] = wgt_min;
               default: in_wgt[p][l] = wgt_t'(r[20 +: wgt_width]);
            endcase
         end
      end
   endtask

   // Random data and in_valid while the DUT should ignore them
   task automatic drive_noise();
      logic [31:0] r;
      fill_inputs(0);
      r = next_rand();
      in_valid = r[30];
   endtask

   // Pops one expected result per out_valid and checks done and busy alongside it
   task automatic watch_outputs();
      forever begin
         @(negedge clk);
         if (rst_n) begin
            if (out_valid) begin
               ov_count++;
               if (exp_last_q.size() == 0) begin
                  $display("out_valid fired at cycle %0d with no result expected", cycles);
                  errors++;
               end else begin
                  for (int p = 0; p < PE; p++) begin
                     check_acc($sformatf("out_acc[%0d]", p), out_acc[p], exp_acc_q.pop_front());
                  end
                  check_flag("done beside out_valid", done, exp_last_q.pop_front());
               end
            end else if (done) begin
               $display("done fired at cycle %0d without out_valid", cycles);
               errors++;
            end
            // The FSM leaves drain on the same edge that raises done
            if (done) begin
               check_flag("busy at done", busy, 1'b0);
            end
         end
      end
   endtask

   // Waits for done, checking that busy holds until then
   task automatic wait_done(input bit noise);
      bit seen;
      seen = 1'b0;
      while (!seen) begin
         @(negedge clk);
         if (done) begin
            seen = 1'b1;
         end else begin
            check_flag("busy before done", busy, 1'b1);
         end
         @(posedge clk);
         #1;
         if (noise) begin
            drive_noise();
         end else begin
            in_valid = 1'b0;
         end
      end
      in_valid = 1'b0;
   endtask

   // Starts one matrix and feeds all its beats, with optional gaps and stray starts
   task automatic stream_matrix(input bit gaps, input int mode, input bit noise);
      logic [31:0] r;
      int          acc_model [PE];
      int          dot;
      int          sf;
      int          nf;
      @(posedge clk);
      #1 start = 1'b1;
      in_valid = 1'b0;
      @(posedge clk);
      #1 start = 1'b0;
      check_flag("busy after start", busy, 1'b1);
      sf = 0;
      nf = 0;
      while (nf < NF) begin
         fill_inputs(mode);
         r = next_rand();
         in_valid = gaps ? (r[29:28] != 2'b00) : 1'b1;
         start = noise ? r[31] : 1'b0;
         // Every beat driven with in_valid high is accepted while the FSM runs
         if (in_valid) begin
            for (int p = 0; p < PE; p++) begin
               dot = 0;
               for (int l = 0; l < SIMD; l++) begin
                  dot += int'(in_act[l]) * int'(in_wgt[p][l]);
               end
               acc_model[p] = (sf == 0) ? dot : acc_model[p] + dot;
            end
            if (sf == SF - 1) begin
               for (int p = 0; p < PE; p++) begin
                  exp_acc_q.push_back(acc_t'(acc_model[p]));
               end
               exp_last_q.push_back(nf == NF - 1);
               sf = 0;
               nf++;
            end else begin
               sf++;
            end
         end
         @(posedge clk);
         #1;
      end
      in_valid = 1'b0;
      start = 1'b0;
   endtask

   // One whole matrix up to its done pulse
   task automatic run_matrix(input bit gaps, input int mode, input bit noise);
      stream_matrix(gaps, mode, noise);
      wait_done(noise);
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      test_err0 = errors;
      tests_run++;
   endtask

   task automatic end_test();
      if (exp_last_q.size() != 0) begin
         $display("%0d results were still expected when the test ended", exp_last_q.size());
         errors++;
      end
      exp_acc_q.delete();
      exp_last_q.delete();
      if (errors == test_err0) begin
         $display("test %0d %s: ok", tests_run, test_name);
      end else begin
         tests_failed++;
         $display("test %0d %s: failed with %0d errors", tests_run, test_name,
                  errors - test_err0);
      end
   endtask

   initial begin
      seed = 32'h38c8_8a11;
      errors = 0;
      tests_run = 0;
      tests_failed = 0;
      ov_count = 0;
      rst_n = 1'b0;
      start = 1'b0;
      in_valid = 1'b0;
      fill_inputs(0);
      fork
         watch_outputs();
      join_none
      repeat (2) @(posedge clk);
      #1 rst_n = 1'b1;

      begin_test("contiguous matrix");
      ov_before = ov_count;
      run_matrix(1'b0, 0, 1'b0);
      if (ov_count - ov_before != NF) begin
         $display("saw %0d out_valid pulses instead of %0d", ov_count - ov_before, NF);
         errors++;
      end
      end_test();

      begin_test("random gaps");
      run_matrix(1'b1, 0, 1'b0);
      run_matrix(1'b1, 0, 1'b0);
      end_test();

      begin_test("ignored input");
      repeat (idle_cycles) begin
         @(posedge clk);
         #1 drive_noise();
         @(negedge clk);
         check_flag("busy in idle", busy, 1'b0);
      end
      run_matrix(1'b1, 0, 1'b1);
      end_test();

      begin_test("done and busy");
      run_matrix(1'b0, 0, 1'b0);
      run_matrix(1'b0, 0, 1'b0);
      end_test();

      begin_test("signed extremes");
      run_matrix(1'b0, 2, 1'b0);
      run_matrix(1'b1, 1, 1'b0);
      end_test();

      begin_test("reset mid-run");
      // Earlier folds have come out, the final one is still in the pipeline
      stream_matrix(1'b0, 0, 1'b0);
      rst_n = 1'b0;
      // The final result and its done pulse are lost with the reset
      exp_acc_q.delete();
      exp_last_q.delete();
      // These cycles would carry drain, out_valid and done without the reset
      repeat (2) begin
         @(posedge clk);
         @(negedge clk);
         check_flag("busy in reset", busy, 1'b0);
         check_flag("out_valid in reset", out_valid, 1'b0);
         check_flag("done in reset", done, 1'b0);
      end
      @(posedge clk);
      #1 rst_n = 1'b1;
      run_matrix(1'b1, 0, 1'b0);
      end_test();

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: src.f
common/mvu_data_pkg.sv
common/mvu_ctrl_pkg.sv
pe/mvu_pe_simd.sv
pe/mvu_pe_adder.sv
pe/mvu_pe_acc.sv
pe/mvu_pe.sv
design/mvu_fold_counter.sv
design/mvu_ctrl_fsm.sv
design/mvu_top.sv
bench/mvu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compiles the MVU testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module mvu_tb -o mvu_sim

out=$(./obj_dir/mvu_sim)
echo "$out"

if grep -q "^TESTS PASSED$" <<< "$out"; then
   exit 0
fi
exit 1
